/* common/adam_pkg.sv */
`default_nettype none

package adam_pkg;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [7:0]  gpio_t;
    // register offset inside one 256 byte region
    typedef logic [7:0]  offset_t;

    // peripheral count and index of each one in the pause and reset vectors
    localparam int NO_PERIPHS   = 2;
    localparam int PERIPH_GPIO  = 0;
    localparam int PERIPH_TIMER = 1;

    // region bases, decoded from the upper address byte
    localparam addr_t BASE_SYSCFG = 16'h0000;
    localparam addr_t BASE_GPIO   = 16'h0100;
    localparam addr_t BASE_TIMER  = 16'h0200;

    // syscfg registers
    localparam offset_t REG_CTRL0    = 8'h00;
    localparam offset_t REG_CTRL1    = 8'h04;
    localparam offset_t REG_STAT0    = 8'h08;
    localparam offset_t REG_STAT1    = 8'h0C;
    localparam offset_t REG_IRQ_PEND = 8'h10;

    // gpio registers
    localparam offset_t GPIO_OUT = 8'h00;
    localparam offset_t GPIO_IN  = 8'h04;

    // timer registers
    localparam offset_t TMR_CTRL = 8'h00;
    localparam offset_t TMR_CMP  = 8'h04;
    localparam offset_t TMR_CNT  = 8'h08;

    typedef enum logic [1:0] {RUN, PAUSING, PAUSED, RESET} pause_state_t;

endpackage

`default_nettype wire

/* syscfg/adam_pause_seq.sv */
`default_nettype none

module adam_pause_seq import adam_pkg::*; (
    input  logic clk,
    input  logic rst_n,

    input  logic pause_bit,
    input  logic rst_bit,

    input  logic pause_ack,
    output logic pause_req,
    output logic periph_rst_n,

    output logic paused,
    output logic in_reset
);

    pause_state_t state_q;
    // follows the RESET state one cycle late
    logic         rst_active_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= RUN;
        end else begin
            case (state_q)
                RUN: begin
                    if (pause_bit || rst_bit) begin
                        state_q <= PAUSING;
                    end
                end
                PAUSING: begin
                    if (pause_ack) begin
                        state_q <= rst_bit ? RESET : PAUSED;
                    end
                end
                PAUSED: begin
                    // reset only a peripheral that has acknowledged
                    if (rst_bit && pause_ack) begin
                        state_q <= RESET;
                    end else if (!rst_bit && !pause_bit) begin
                        state_q <= RUN;
                    end
                end
                RESET: begin
                    // leave reset first, the pause drops later
                    if (!rst_bit) begin
                        state_q <= PAUSED;
                    end
                end
                default: state_q <= RUN;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_active_q <= 1'b0;
        end else begin
            rst_active_q <= (state_q == RESET);
        end
    end

    assign pause_req    = (state_q != RUN);
    assign periph_rst_n = rst_n & ~rst_active_q;
    assign paused       = (state_q == PAUSED) || (state_q == RESET);
    assign in_reset     = (state_q == RESET) || rst_active_q;

endmodule

`default_nettype wire

/* syscfg/adam_syscfg.sv */
`default_nettype none

module adam_syscfg import adam_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  sel,
    input  logic                  we,
    input  offset_t               offset,
    input  data_t                 wdata,
    output data_t                 rdata,

    input  logic [NO_PERIPHS-1:0] pause_ack,
    output logic [NO_PERIPHS-1:0] pause_req,
    output logic [NO_PERIPHS-1:0] periph_rst_n,
    output logic [NO_PERIPHS-1:0] periph_paused,

    input  logic                  tmr_irq,
    output logic                  irq
);

    logic [NO_PERIPHS-1:0] rst_bit_q;
    logic [NO_PERIPHS-1:0] pause_bit_q;
    logic [NO_PERIPHS-1:0] paused;
    logic [NO_PERIPHS-1:0] in_reset;
    // only the timer raises interrupts, so pending bit 0 stays zero
    logic                  tmr_pend_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_bit_q   <= '0;
            pause_bit_q <= '0;
        end else if (sel && we) begin
            case (offset)
                REG_CTRL0: begin
                    rst_bit_q[0]   <= wdata[0];
                    pause_bit_q[0] <= wdata[1];
                end
                REG_CTRL1: begin
                    rst_bit_q[1]   <= wdata[0];
                    pause_bit_q[1] <= wdata[1];
                end
                default: ;
            endcase
        end
    end

    // a new pulse wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tmr_pend_q <= 1'b0;
        end else if (tmr_irq) begin
            tmr_pend_q <= 1'b1;
        end else if (sel && we && offset == REG_IRQ_PEND && wdata[1]) begin
            tmr_pend_q <= 1'b0;
        end
    end

    assign irq = tmr_pend_q;

    for (genvar i = 0; i < NO_PERIPHS; i++) begin : g_seq
        adam_pause_seq u_pause_seq (
            .clk          (clk),
            .rst_n        (rst_n),
            .pause_bit    (pause_bit_q[i]),
            .rst_bit      (rst_bit_q[i]),
            .pause_ack    (pause_ack[i]),
            .pause_req    (pause_req[i]),
            .periph_rst_n (periph_rst_n[i]),
            .paused       (paused[i]),
            .in_reset     (in_reset[i])
        );

        // ack drops while the peripheral sits in reset, so keep it fenced off
        assign periph_paused[i] = pause_ack[i] | paused[i] | in_reset[i];
    end

    always_comb begin
        rdata = '0;
        case (offset)
            REG_CTRL0:    rdata = {30'b0, pause_bit_q[0], rst_bit_q[0]};
            REG_CTRL1:    rdata = {30'b0, pause_bit_q[1], rst_bit_q[1]};
            REG_STAT0:    rdata = {30'b0, in_reset[0], paused[0]};
            REG_STAT1:    rdata = {30'b0, in_reset[1], paused[1]};
            REG_IRQ_PEND: rdata = {30'b0, tmr_pend_q, 1'b0};
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/adam_fabric.sv */
`default_nettype none

module adam_fabric import adam_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  bus_req,
    input  logic                  bus_we,
    input  addr_t                 bus_addr,
    input  data_t                 bus_wdata,
    output logic                  bus_ack,
    output logic                  bus_err,
    output data_t                 bus_rdata,

    input  logic [NO_PERIPHS-1:0] periph_paused,

    output logic                  cfg_sel,
    output logic                  cfg_we,
    output offset_t               cfg_offset,
    output data_t                 cfg_wdata,
    input  data_t                 cfg_rdata,

    output logic                  gpio_sel,
    output logic                  gpio_we,
    output offset_t               gpio_offset,
    output data_t                 gpio_wdata,
    input  data_t                 gpio_rdata,

    output logic                  tmr_sel,
    output logic                  tmr_we,
    output offset_t               tmr_offset,
    output data_t                 tmr_wdata,
    input  data_t                 tmr_rdata
);

    logic [7:0] region;
    logic       any_sel;
    data_t      rd_mux;

    assign region = bus_addr[15:8];

    // paused targets never see the strobe
    assign cfg_sel  = bus_req && (region == BASE_SYSCFG[15:8]);
    assign gpio_sel = bus_req && (region == BASE_GPIO[15:8]) && !periph_paused[PERIPH_GPIO];
    assign tmr_sel  = bus_req && (region == BASE_TIMER[15:8]) && !periph_paused[PERIPH_TIMER];
    assign any_sel  = cfg_sel || gpio_sel || tmr_sel;

    assign cfg_we      = bus_we;
    assign cfg_offset  = bus_addr[7:0];
    assign cfg_wdata   = bus_wdata;
    assign gpio_we     = bus_we;
    assign gpio_offset = bus_addr[7:0];
    assign gpio_wdata  = bus_wdata;
    assign tmr_we      = bus_we;
    assign tmr_offset  = bus_addr[7:0];
    assign tmr_wdata   = bus_wdata;

    always_comb begin
        rd_mux = '0;
        if (cfg_sel) begin
            rd_mux = cfg_rdata;
        end else if (gpio_sel) begin
            rd_mux = gpio_rdata;
        end else if (tmr_sel) begin
            rd_mux = tmr_rdata;
        end
    end

    // fixed one cycle reply
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_ack <= 1'b0;
            bus_err <= 1'b0;
        end else begin
            bus_ack <= bus_req;
            bus_err <= bus_req && !any_sel;
        end
    end

    // writes and refused accesses return zero
    always_ff @(posedge clk) begin
        bus_rdata <= (any_sel && !bus_we) ? rd_mux : '0;
    end

endmodule

`default_nettype wire

/* periph/adam_periph_gpio.sv */
`default_nettype none

module adam_periph_gpio import adam_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    sel,
    input  logic    we,
    input  offset_t offset,
    input  data_t   wdata,
    output data_t   rdata,

    input  logic    pause_req,
    output logic    pause_ack,

    input  gpio_t   gpio_in,
    output gpio_t   gpio_out
);

    gpio_t in_meta_q;
    gpio_t in_sync_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req;
        end
    end

    // written only by accesses the fabric lets through
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (sel && we && offset == GPIO_OUT) begin
            gpio_out <= wdata[7:0];
        end
    end

    // two flop synchronizer for the pins
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_in;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        case (offset)
            GPIO_OUT: rdata = {24'b0, gpio_out};
            GPIO_IN:  rdata = {24'b0, in_sync_q};
            default:  rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* periph/adam_periph_timer.sv */
`default_nettype none

module adam_periph_timer import adam_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    sel,
    input  logic    we,
    input  offset_t offset,
    input  data_t   wdata,
    output data_t   rdata,

    input  logic    pause_req,
    output logic    pause_ack,

    output logic    irq
);

    logic  en_q;
    data_t cmp_q;
    data_t cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pause_ack <= 1'b0;
        end else begin
            pause_ack <= pause_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q  <= 1'b0;
            cmp_q <= '0;
        end else if (sel && we) begin
            case (offset)
                TMR_CTRL: en_q  <= wdata[0];
                TMR_CMP:  cmp_q <= wdata;
                default: ;
            endcase
        end
    end

    // counter frozen while paused, wraps to zero on match
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
            irq   <= 1'b0;
        end else if (en_q && !pause_ack) begin
            if (cnt_q == cmp_q) begin
                cnt_q <= '0;
                irq   <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 32'd1;
                irq   <= 1'b0;
            end
        end else begin
            irq <= 1'b0;
        end
    end

    always_comb begin
        case (offset)
            TMR_CTRL: rdata = {31'b0, en_q};
            TMR_CMP:  rdata = cmp_q;
            TMR_CNT:  rdata = cnt_q;
            default:  rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/adam.sv */
`default_nettype none

module adam import adam_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  logic  bus_req,
    input  logic  bus_we,
    input  addr_t bus_addr,
    input  data_t bus_wdata,
    output logic  bus_ack,
    output logic  bus_err,
    output data_t bus_rdata,

    input  gpio_t gpio_in,
    output gpio_t gpio_out,
    output logic  irq
);

    logic                  cfg_sel;
    logic                  cfg_we;
    offset_t               cfg_offset;
    data_t                 cfg_wdata;
    data_t                 cfg_rdata;
    logic                  gpio_sel;
    logic                  gpio_we;
    offset_t               gpio_offset;
    data_t                 gpio_wdata;
    data_t                 gpio_rdata;
    logic                  tmr_sel;
    logic                  tmr_we;
    offset_t               tmr_offset;
    data_t                 tmr_wdata;
    data_t                 tmr_rdata;

    logic [NO_PERIPHS-1:0] pause_req;
    logic [NO_PERIPHS-1:0] pause_ack;
    logic [NO_PERIPHS-1:0] periph_rst_n;
    logic [NO_PERIPHS-1:0] periph_paused;
    logic                  tmr_irq;

    adam_fabric u_fabric (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus_req       (bus_req),
        .bus_we        (bus_we),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_ack       (bus_ack),
        .bus_err       (bus_err),
        .bus_rdata     (bus_rdata),
        .periph_paused (periph_paused),
        .cfg_sel       (cfg_sel),
        .cfg_we        (cfg_we),
        .cfg_offset    (cfg_offset),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .gpio_sel      (gpio_sel),
        .gpio_we       (gpio_we),
        .gpio_offset   (gpio_offset),
        .gpio_wdata    (gpio_wdata),
        .gpio_rdata    (gpio_rdata),
        .tmr_sel       (tmr_sel),
        .tmr_we        (tmr_we),
        .tmr_offset    (tmr_offset),
        .tmr_wdata     (tmr_wdata),
        .tmr_rdata     (tmr_rdata)
    );

    adam_syscfg u_syscfg (
        .clk           (clk),
        .rst_n         (rst_n),
        .sel           (cfg_sel),
        .we            (cfg_we),
        .offset        (cfg_offset),
        .wdata         (cfg_wdata),
        .rdata         (cfg_rdata),
        .pause_ack     (pause_ack),
        .pause_req     (pause_req),
        .periph_rst_n  (periph_rst_n),
        .periph_paused (periph_paused),
        .tmr_irq       (tmr_irq),
        .irq           (irq)
    );

    // each peripheral runs on its own reset from syscfg
    adam_periph_gpio u_gpio (
        .clk       (clk),
        .rst_n     (periph_rst_n[PERIPH_GPIO]),
        .sel       (gpio_sel),
        .we        (gpio_we),
        .offset    (gpio_offset),
        .wdata     (gpio_wdata),
        .rdata     (gpio_rdata),
        .pause_req (pause_req[PERIPH_GPIO]),
        .pause_ack (pause_ack[PERIPH_GPIO]),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out)
    );

    adam_periph_timer u_timer (
        .clk       (clk),
        .rst_n     (periph_rst_n[PERIPH_TIMER]),
        .sel       (tmr_sel),
        .we        (tmr_we),
        .offset    (tmr_offset),
        .wdata     (tmr_wdata),
        .rdata     (tmr_rdata),
        .pause_req (pause_req[PERIPH_TIMER]),
        .pause_ack (pause_ack[PERIPH_TIMER]),
        .irq       (tmr_irq)
    );

endmodule

`default_nettype wire

/* verification/adam_checker.sv */
`default_nettype none

module adam_checker import adam_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  logic  bus_req,
    input  logic  bus_we,
    input  addr_t bus_addr,
    input  data_t bus_wdata,
    input  logic  bus_ack,
    input  logic  bus_err,
    input  data_t bus_rdata,

    input  gpio_t gpio_in,
    input  gpio_t gpio_out,
    input  logic  irq,

    input  int    test_id,
    output int    errors,
    output int    checks
);

    timeunit 1ns;
    timeprecision 1ps;

    // shadow of the register map, {pause, reset} per peripheral
    logic [NO_PERIPHS-1:0][1:0] ctrl_q;
    // STAT is only predictable once the sequencer has settled
    logic [NO_PERIPHS-1:0]      settled_q;
    gpio_t                      gpio_q;
    logic                       tmr_en_q;
    data_t                      tmr_cmp_q;
    logic                       pend_q;
    logic                       armed_q;
    int                         cycle_q;
    int                         deadline_q;
    // bus_ack is due on the edge after each request
    logic                       ack_due_q;
    // gpio_in as a reply sees it, two sync stages plus the reply register
    gpio_t                      in_d1_q;
    gpio_t                      in_d2_q;
    gpio_t                      in_d3_q;

    // request held until its reply
    logic                       req_we;
    addr_t                      req_addr;
    data_t                      req_wdata;

    function automatic string test_name(input int id);
        case (id)
            1:       return "gpio_out_readback";
            2:       return "gpio_in_sync";
            3:       return "gpio_pause";
            4:       return "gpio_reset";
            5:       return "timer_irq";
            6:       return "unmapped";
            default: return "idle";
        endcase
    endfunction

    function automatic logic expected_err(input addr_t addr);
        case (addr[15:8])
            BASE_SYSCFG[15:8]: return 1'b0;
            BASE_GPIO[15:8]:   return |ctrl_q[PERIPH_GPIO];
            BASE_TIMER[15:8]:  return |ctrl_q[PERIPH_TIMER];
            default:           return 1'b1;
        endcase
    endfunction

    // read data as the register map defines it
    function automatic data_t expected_read(input addr_t addr);
        offset_t off;
        off = addr[7:0];
        case (addr[15:8])
            BASE_SYSCFG[15:8]: begin
                case (off)
                    REG_CTRL0:    return {30'b0, ctrl_q[0]};
                    REG_CTRL1:    return {30'b0, ctrl_q[1]};
                    // in reset when the reset bit is set, paused for either bit
                    REG_STAT0:    return {30'b0, ctrl_q[0][0], |ctrl_q[0]};
                    REG_STAT1:    return {30'b0, ctrl_q[1][0], |ctrl_q[1]};
                    REG_IRQ_PEND: return {30'b0, pend_q, 1'b0};
                    default:      return '0;
                endcase
            end
            BASE_GPIO[15:8]: begin
                if (|ctrl_q[PERIPH_GPIO]) begin
                    return '0;
                end
                case (off)
                    GPIO_OUT: return {24'b0, gpio_q};
                    GPIO_IN:  return {24'b0, in_d3_q};
                    default:  return '0;
                endcase
            end
            BASE_TIMER[15:8]: begin
                if (|ctrl_q[PERIPH_TIMER]) begin
                    return '0;
                end
                case (off)
                    TMR_CTRL: return {31'b0, tmr_en_q};
                    TMR_CMP:  return tmr_cmp_q;
                    default:  return '0;
                endcase
            end
            default: return '0;
        endcase
    endfunction

    // bits whose value the model can predict
    function automatic data_t read_mask(input addr_t addr);
        offset_t off;
        off = addr[7:0];
        if (addr[15:8] == BASE_SYSCFG[15:8]) begin
            if (off == REG_STAT0 && !settled_q[0]) begin
                return 32'hFFFF_FFFC;
            end
            if (off == REG_STAT1 && !settled_q[1]) begin
                return 32'hFFFF_FFFC;
            end
            if (off == REG_IRQ_PEND && tmr_en_q && !pend_q) begin
                return 32'hFFFF_FFFD;
            end
        end
        if (addr[15:8] == BASE_TIMER[15:8] && off == TMR_CNT) begin
            return '0;
        end
        return '1;
    endfunction

    task automatic compare(input string what, input data_t exp, input data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name(test_id), what, exp, act);
        end
    endtask

    task automatic apply_write();
        offset_t off;
        int      idx;
        off = req_addr[7:0];
        case (req_addr[15:8])
            BASE_SYSCFG[15:8]: begin
                if (off == REG_CTRL0 || off == REG_CTRL1) begin
                    idx = (off == REG_CTRL1) ? 1 : 0;
                    ctrl_q[idx] = req_wdata[1:0];
                    settled_q[idx] = 1'b0;
                    // a reset request clears the peripheral once sequenced
                    if (req_wdata[0] && idx == PERIPH_GPIO) begin
                        gpio_q = '0;
                    end
                    if (req_wdata[0] && idx == PERIPH_TIMER) begin
                        tmr_en_q  = 1'b0;
                        tmr_cmp_q = '0;
                    end
                end
                if (off == REG_IRQ_PEND && req_wdata[1]) begin
                    pend_q = 1'b0;
                end
            end
            BASE_GPIO[15:8]: begin
                if (off == GPIO_OUT) begin
                    gpio_q = req_wdata[7:0];
                end
            end
            BASE_TIMER[15:8]: begin
                if (off == TMR_CMP) begin
                    tmr_cmp_q = req_wdata;
                end
                if (off == TMR_CTRL) begin
                    tmr_en_q = req_wdata[0];
                    if (req_wdata[0]) begin
                        armed_q    = 1'b1;
                        deadline_q = cycle_q + int'(tmr_cmp_q) + 4;
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_reply();
        data_t exp;
        data_t mask;
        int    idx;
        exp  = req_we ? '0 : expected_read(req_addr);
        mask = req_we ? '1 : read_mask(req_addr);
        compare("bus_err", {31'b0, expected_err(req_addr)}, {31'b0, bus_err});
        compare("bus_rdata", exp & mask, bus_rdata & mask);
        if (req_we && !expected_err(req_addr)) begin
            apply_write();
        end
        if (!req_we && req_addr[15:8] == BASE_SYSCFG[15:8]
                && (req_addr[7:0] == REG_STAT0 || req_addr[7:0] == REG_STAT1)) begin
            idx = (req_addr[7:0] == REG_STAT1) ? 1 : 0;
            if (bus_rdata[1:0] == {ctrl_q[idx][0], |ctrl_q[idx]}) begin
                settled_q[idx] = 1'b1;
            end
        end
        // a refused access must leave the pins alone as well
        if (req_addr[15:8] == BASE_GPIO[15:8]) begin
            compare("gpio_out", {24'b0, gpio_q}, {24'b0, gpio_out});
        end
        if (!tmr_en_q) begin
            compare("irq", {31'b0, pend_q}, {31'b0, irq});
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q     = '0;
            settled_q  = '1;
            gpio_q     = '0;
            tmr_en_q   = 1'b0;
            tmr_cmp_q  = '0;
            pend_q     = 1'b0;
            armed_q    = 1'b0;
            cycle_q    = 0;
            deadline_q = 0;
            ack_due_q  = 1'b0;
            in_d1_q    = '0;
            in_d2_q    = '0;
            in_d3_q    = '0;
            req_we     = 1'b0;
            req_addr   = '0;
            req_wdata  = '0;
            errors     = 0;
            checks     = 0;
        end else begin
            cycle_q++;
            compare("bus_ack", {31'b0, ack_due_q}, {31'b0, bus_ack});
            if (bus_ack) begin
                check_reply();
            end
            if (armed_q && irq) begin
                armed_q = 1'b0;
            end
            if (tmr_en_q && irq) begin
                pend_q = 1'b1;
            end
            if (armed_q && cycle_q > deadline_q) begin
                errors++;
                $display("%s: irq did not rise within compare value plus 4 cycles",
                         test_name(test_id));
                armed_q = 1'b0;
            end
            if (bus_req) begin
                req_we    = bus_we;
                req_addr  = bus_addr;
                req_wdata = bus_wdata;
            end
            ack_due_q = bus_req;
            in_d3_q   = in_d2_q;
            in_d2_q   = in_d1_q;
            in_d1_q   = gpio_in;
        end
    end

endmodule

`default_nettype wire

/* verification/adam_tb.sv */
`default_nettype none

module adam_tb import adam_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // budget per bus transaction, status polls included
    localparam int PLANNED_TXNS   = 64;
    localparam int CYCLES_PER_TXN = 200;

    logic  clk;
    logic  rst_n;
    logic  bus_req;
    logic  bus_we;
    addr_t bus_addr;
    data_t bus_wdata;
    logic  bus_ack;
    logic  bus_err;
    data_t bus_rdata;
    gpio_t gpio_in;
    gpio_t gpio_out;
    logic  irq;
    int    test_id;
    int    errors;
    int    checks;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    adam u_adam (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_err   (bus_err),
        .bus_rdata (bus_rdata),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .irq       (irq)
    );

    adam_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_ack   (bus_ack),
        .bus_err   (bus_err),
        .bus_rdata (bus_rdata),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .irq       (irq),
        .test_id   (test_id),
        .errors    (errors),
        .checks    (checks)
    );

    // one strobe, then wait for the reply
    task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                              output data_t rdata);
        @(negedge clk);
        bus_req   = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = wdata;
        @(negedge clk);
        bus_req = 1'b0;
        while (!bus_ack) begin
            @(negedge clk);
        end
        rdata = bus_rdata;
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata);
        data_t discard;
        bus_access(1'b1, addr, wdata, discard);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_access(1'b0, addr, '0, rdata);
    endtask

    task automatic wait_status(input addr_t addr, input logic [1:0] want);
        data_t stat;
        do begin
            bus_read(addr, stat);
        end while (stat[1:0] != want);
    endtask

    initial begin
        data_t rd;
        data_t val;
        rst_n     = 1'b0;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        gpio_in   = '0;
        test_id   = 0;
        void'($urandom(32'h2d68));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_id = 1;
        repeat (4) begin
            bus_write(BASE_GPIO + GPIO_OUT, $urandom);
            bus_read(BASE_GPIO + GPIO_OUT, rd);
        end

        test_id = 2;
        repeat (3) begin
            @(negedge clk);
            gpio_in = gpio_t'($urandom);
            // first read that can see the synchronized value
            @(negedge clk);
            bus_read(BASE_GPIO + GPIO_IN, rd);
        end

        test_id = 3;
        val = $urandom;
        bus_write(BASE_GPIO + GPIO_OUT, val);
        bus_write(BASE_SYSCFG + REG_CTRL0, 32'h2);
        wait_status(BASE_SYSCFG + REG_STAT0, 2'b01);
        bus_write(BASE_GPIO + GPIO_OUT, ~val);
        bus_read(BASE_GPIO + GPIO_OUT, rd);
        bus_write(BASE_SYSCFG + REG_CTRL0, 32'h0);
        wait_status(BASE_SYSCFG + REG_STAT0, 2'b00);
        bus_read(BASE_GPIO + GPIO_OUT, rd);

        test_id = 4;
        bus_write(BASE_GPIO + GPIO_OUT, $urandom | 32'h1);
        bus_write(BASE_SYSCFG + REG_CTRL0, 32'h1);
        wait_status(BASE_SYSCFG + REG_STAT0, 2'b11);
        bus_read(BASE_SYSCFG + REG_STAT0, rd);
        bus_write(BASE_SYSCFG + REG_CTRL0, 32'h0);
        wait_status(BASE_SYSCFG + REG_STAT0, 2'b00);
        bus_read(BASE_SYSCFG + REG_STAT0, rd);
        bus_read(BASE_GPIO + GPIO_OUT, rd);

        test_id = 5;
        val = 32'd8 + ($urandom % 32'd24);
        bus_write(BASE_TIMER + TMR_CMP, val);
        bus_read(BASE_TIMER + TMR_CMP, rd);
        bus_write(BASE_TIMER + TMR_CTRL, 32'h1);
        while (!irq) begin
            @(negedge clk);
        end
        bus_read(BASE_SYSCFG + REG_IRQ_PEND, rd);
        // stop the timer so no new pulse races the clear
        bus_write(BASE_TIMER + TMR_CTRL, 32'h0);
        bus_write(BASE_SYSCFG + REG_IRQ_PEND, 32'h2);
        bus_read(BASE_SYSCFG + REG_IRQ_PEND, rd);

        test_id = 6;
        bus_read(16'h0300, rd);
        bus_write(16'h0404, $urandom);
        bus_read(16'hFF08, rd);
        val = $urandom;
        bus_read({8'd3 + val[15:8] % 8'd253, val[7:0]}, rd);

        repeat (4) @(negedge clk);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (PLANNED_TXNS * CYCLES_PER_TXN) @(posedge clk);
        $display("watchdog expired, the run did not finish within %0d cycles",
                 PLANNED_TXNS * CYCLES_PER_TXN);
        $display("checks run: %0d, errors: %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* adam.f */
common/adam_pkg.sv
syscfg/adam_pause_seq.sv
syscfg/adam_syscfg.sv
logic/adam_fabric.sv
periph/adam_periph_gpio.sv
periph/adam_periph_timer.sv
logic/adam.sv
verification/adam_checker.sv
verification/adam_tb.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --timescale 1ns/1ps -j 0
TOP      := adam_tb
FILELIST := adam.f
PASS_MSG := ALL CHECKS PASSED

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
